//--- nes_glue_params.svh
// widths, host register map, phase numbers and button positions
// button order from bit 7 down to bit 0 is R L D U start select B A
// host addresses are 8-bit, phase numbers must stay below NES_PHASES
`ifndef NES_GLUE_PARAMS_SVH
`define NES_GLUE_PARAMS_SVH

`define NES_BTN_W      8
`define DS_BYTE_W      8
`define MEM_ADDR_W     22     // 4MB address space
`define MEM_DATA_W     8
`define HOST_ADDR_W    8

`define HOST_REG_CONF  8'h35  // bit 0 holds the loader in reset
`define HOST_REG_DATA  8'h37
`define HOST_REG_BTN1  8'h40
`define HOST_REG_BTN2  8'h41

`define NES_PHASES     5
`define MEM_PHASE      0
`define NES_PHASE      4

`define BTN_DOWN       5
`define BTN_SELECT     2

`endif

//--- nes_glue_pkg.sv
// shared types for the console glue logic
// all widths come from the params header, keep the two in step
// phase_t values are the phase numbers of the slot scheduler
`default_nettype none

`include "nes_glue_params.svh"

package nes_glue_pkg;

  typedef logic [`NES_BTN_W-1:0]   nes_btn_t;    // R L D U start select B A
  typedef logic [`DS_BYTE_W-1:0]   ds_byte_t;    // raw pad byte, active low
  typedef logic [`HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [`MEM_ADDR_W-1:0]  mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0]  mem_data_t;

  // one round of the memory slot, in order
  typedef enum logic [$clog2(`NES_PHASES)-1:0] {
    PH_MEM,   // memory command issued
    PH_ACT,   // row activate
    PH_RW,    // read or write
    PH_WAIT,
    PH_NES    // read data ready, core steps
  } phase_t;

endpackage

`default_nettype wire

//--- host_reg_bank.sv
// register bank written by the serial host, no read-back
// i_host_write is a one-cycle strobe qualifying address and data
// loader reset is combinational and includes the system reset
`timescale 1ns/1ps
`default_nettype none

`include "nes_glue_params.svh"

module host_reg_bank (
  input  wire                           clk,
  input  wire                           sys_resetn,
  input  wire nes_glue_pkg::host_addr_t i_host_addr,
  input  wire nes_glue_pkg::mem_data_t  i_host_data,
  input  wire                           i_host_write,
  input  wire nes_glue_pkg::nes_btn_t   i_pad1_buttons,  // mapped player 1 buttons
  output nes_glue_pkg::mem_data_t       o_loader_byte,
  output logic                          o_loader_byte_valid,
  output logic                          o_loader_reset,
  output nes_glue_pkg::nes_btn_t        o_override_p1,
  output nes_glue_pkg::nes_btn_t        o_override_p2
);

  logic                    conf_wr;
  logic                    data_wr;
  logic                    btn1_wr;
  logic                    btn2_wr;
  logic                    hotkey;
  nes_glue_pkg::mem_data_t conf_q;

  // address decode
  assign conf_wr = i_host_write && (i_host_addr == `HOST_REG_CONF);
  assign data_wr = i_host_write && (i_host_addr == `HOST_REG_DATA);
  assign btn1_wr = i_host_write && (i_host_addr == `HOST_REG_BTN1);
  assign btn2_wr = i_host_write && (i_host_addr == `HOST_REG_BTN2);

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_q              <= '0;
      o_override_p1       <= '0;
      o_override_p2       <= '0;
      o_loader_byte_valid <= 1'b0;
    end else begin
      o_loader_byte_valid <= data_wr;  // one cycle per ROM byte
      if (conf_wr) begin
        conf_q <= i_host_data;
      end
      if (btn1_wr) begin
        o_override_p1 <= i_host_data;
      end
      if (btn2_wr) begin
        o_override_p2 <= i_host_data;
      end
    end
  end

  // ROM byte, only meaningful with the valid strobe
  always_ff @(posedge clk) begin
    if (data_wr) begin
      o_loader_byte <= i_host_data;
    end
  end

  // select + down is the home combo on most pads
  assign hotkey = i_pad1_buttons[`BTN_SELECT] & i_pad1_buttons[`BTN_DOWN];

  assign o_loader_reset = ~sys_resetn | conf_q[0] | hotkey;

endmodule

`default_nettype wire

//--- joypad_port.sv
// one console joypad port
// raw pad bytes are active low, USB buttons are active high in button order
// shift happens on the falling edge of i_pad_clock as seen in clk
// strobe level wins over a clock edge in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "nes_glue_params.svh"

module joypad_port (
  input  wire                         clk,
  input  wire                         sys_resetn,
  input  wire nes_glue_pkg::ds_byte_t i_ds_byte0,
  input  wire nes_glue_pkg::ds_byte_t i_ds_byte1,
  input  wire nes_glue_pkg::nes_btn_t i_usb_buttons,
  input  wire nes_glue_pkg::nes_btn_t i_override,    // host forced buttons
  input  wire                         i_strobe,
  input  wire                         i_pad_clock,
  output nes_glue_pkg::nes_btn_t      o_pad_buttons,
  output logic                        o_serial_bit
);

  nes_glue_pkg::nes_btn_t ds_buttons;
  nes_glue_pkg::nes_btn_t shift_q;
  logic                   pad_clock_q;
  logic                   clock_fall;

  // dualshock byte 0: L D R U start R3 L3 select (bit 7 down to 0)
  // byte 1 gives cross on bit 6 and circle on bit 5
  assign ds_buttons = {
    ~i_ds_byte0[5],  // R
    ~i_ds_byte0[7],  // L
    ~i_ds_byte0[6],  // D
    ~i_ds_byte0[4],  // U
    ~i_ds_byte0[3],  // start
    ~i_ds_byte0[0],  // select
    ~i_ds_byte1[6],  // B from cross
    ~i_ds_byte1[5]   // A from circle
  };

  assign o_pad_buttons = ds_buttons | i_usb_buttons;

  assign clock_fall = pad_clock_q & ~i_pad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      pad_clock_q <= 1'b0;
      shift_q     <= '0;
    end else begin
      pad_clock_q <= i_pad_clock;
      if (i_strobe) begin
        shift_q <= i_override | o_pad_buttons;  // latch while strobe held
      end else if (clock_fall) begin
        shift_q <= {1'b0, shift_q[`NES_BTN_W-1:1]};  // A first, then zeros
      end
    end
  end

  assign o_serial_bit = shift_q[0];

endmodule

`default_nettype wire

//--- mem_slot_scheduler.sv
// memory slot scheduler, one round is five clk cycles
// memory gets phase 0, core steps on phase 4 once the loader is done
// loader writes take the memory port at any phase, no busy handling
// memory command outputs are combinational
`timescale 1ns/1ps
`default_nettype none

`include "nes_glue_params.svh"

module mem_slot_scheduler (
  input  wire                          clk,
  input  wire                          sys_resetn,
  input  wire                          i_loader_done,
  input  wire                          i_cpu_read,
  input  wire                          i_ppu_read,
  input  wire                          i_nes_write,
  input  wire nes_glue_pkg::mem_addr_t i_nes_addr,
  input  wire nes_glue_pkg::mem_data_t i_nes_data,
  input  wire                          i_loader_write,
  input  wire                          i_loader_refresh,
  input  wire nes_glue_pkg::mem_addr_t i_loader_addr,
  input  wire nes_glue_pkg::mem_data_t i_loader_data,
  output logic                         o_run_nes,
  output logic                         o_mem_read_cpu,
  output logic                         o_mem_read_ppu,
  output logic                         o_mem_write,
  output logic                         o_mem_refresh,
  output nes_glue_pkg::mem_addr_t      o_mem_addr,
  output nes_glue_pkg::mem_data_t      o_mem_data
);

  // phase   | 0 MEM | 1 ACT | 2 RW | 3 WAIT | 4 NES |
  // memory  |  cmd  |  act  | r/w  |        | dout  |
  // core                                    |  run  |
  nes_glue_pkg::phase_t phase_q;
  nes_glue_pkg::phase_t phase_d;
  logic                 run_mem;
  logic                 core_req;

  always_comb begin
    case (phase_q)
      nes_glue_pkg::PH_MEM:  phase_d = nes_glue_pkg::PH_ACT;
      nes_glue_pkg::PH_ACT:  phase_d = nes_glue_pkg::PH_RW;
      nes_glue_pkg::PH_RW:   phase_d = nes_glue_pkg::PH_WAIT;
      nes_glue_pkg::PH_WAIT: phase_d = nes_glue_pkg::PH_NES;
      default:               phase_d = nes_glue_pkg::PH_MEM;  // wrap, also unused codes
    endcase
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      phase_q <= nes_glue_pkg::PH_MEM;
    end else begin
      phase_q <= phase_d;
    end
  end

  // core held off until the ROM is in memory
  assign run_mem   = (phase_q == nes_glue_pkg::phase_t'(`MEM_PHASE)) & i_loader_done;
  assign o_run_nes = (phase_q == nes_glue_pkg::phase_t'(`NES_PHASE)) & i_loader_done;

  assign core_req = i_cpu_read | i_ppu_read | i_nes_write;

  assign o_mem_read_cpu = i_cpu_read & run_mem;
  assign o_mem_read_ppu = i_ppu_read & run_mem;
  assign o_mem_write    = (i_nes_write & run_mem) | i_loader_write;

  // loader owns address and data whenever it writes
  assign o_mem_addr = i_loader_write ? i_loader_addr : i_nes_addr;
  assign o_mem_data = i_loader_write ? i_loader_data : i_nes_data;

  // idle memory slot turns into a refresh
  assign o_mem_refresh = (run_mem & ~core_req & ~i_loader_write)
                       | (i_loader_refresh & ~i_loader_write);

endmodule

`default_nettype wire

//--- nes_glue_top.sv
// glue between console core, ROM loader, memory controller and pads
// core, loader and memory controller sit outside on loose ports
// joypad bit 0 is player 1, bit 1 is player 2
`timescale 1ns/1ps
`default_nettype none

`include "nes_glue_params.svh"

module nes_glue_top (
  input  wire                           clk,
  input  wire                           sys_resetn,
  input  wire nes_glue_pkg::host_addr_t i_host_addr,
  input  wire nes_glue_pkg::mem_data_t  i_host_data,
  input  wire                           i_host_write,
  input  wire nes_glue_pkg::ds_byte_t   i_ds_byte0_p1,
  input  wire nes_glue_pkg::ds_byte_t   i_ds_byte1_p1,
  input  wire nes_glue_pkg::nes_btn_t   i_usb_btn_p1,
  input  wire nes_glue_pkg::ds_byte_t   i_ds_byte0_p2,
  input  wire nes_glue_pkg::ds_byte_t   i_ds_byte1_p2,
  input  wire nes_glue_pkg::nes_btn_t   i_usb_btn_p2,
  input  wire                           i_joy_strobe,
  input  wire [1:0]                     i_joy_clock,
  output wire [1:0]                     o_joy_data,
  output wire nes_glue_pkg::mem_data_t  o_loader_byte,
  output wire                           o_loader_byte_valid,
  output wire                           o_loader_reset,
  input  wire                           i_loader_done,
  input  wire                           i_cpu_read,
  input  wire                           i_ppu_read,
  input  wire                           i_nes_write,
  input  wire nes_glue_pkg::mem_addr_t  i_nes_addr,
  input  wire nes_glue_pkg::mem_data_t  i_nes_data,
  input  wire                           i_loader_write,
  input  wire                           i_loader_refresh,
  input  wire nes_glue_pkg::mem_addr_t  i_loader_addr,
  input  wire nes_glue_pkg::mem_data_t  i_loader_data,
  output wire                           o_run_nes,
  output wire                           o_mem_read_cpu,
  output wire                           o_mem_read_ppu,
  output wire                           o_mem_write,
  output wire                           o_mem_refresh,
  output wire nes_glue_pkg::mem_addr_t  o_mem_addr,
  output wire nes_glue_pkg::mem_data_t  o_mem_data
);

  nes_glue_pkg::nes_btn_t pad1_buttons;  // feeds the reset hotkey
  nes_glue_pkg::nes_btn_t override_p1;
  nes_glue_pkg::nes_btn_t override_p2;

  host_reg_bank u_host_regs (
    .clk                 (clk),
    .sys_resetn          (sys_resetn),
    .i_host_addr         (i_host_addr),
    .i_host_data         (i_host_data),
    .i_host_write        (i_host_write),
    .i_pad1_buttons      (pad1_buttons),
    .o_loader_byte       (o_loader_byte),
    .o_loader_byte_valid (o_loader_byte_valid),
    .o_loader_reset      (o_loader_reset),
    .o_override_p1       (override_p1),
    .o_override_p2       (override_p2)
  );

  joypad_port u_pad_p1 (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .i_ds_byte0    (i_ds_byte0_p1),
    .i_ds_byte1    (i_ds_byte1_p1),
    .i_usb_buttons (i_usb_btn_p1),
    .i_override    (override_p1),
    .i_strobe      (i_joy_strobe),
    .i_pad_clock   (i_joy_clock[0]),
    .o_pad_buttons (pad1_buttons),
    .o_serial_bit  (o_joy_data[0])
  );

  // player 2 has no hotkey, merged buttons stay internal
  joypad_port u_pad_p2 (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .i_ds_byte0    (i_ds_byte0_p2),
    .i_ds_byte1    (i_ds_byte1_p2),
    .i_usb_buttons (i_usb_btn_p2),
    .i_override    (override_p2),
    .i_strobe      (i_joy_strobe),
    .i_pad_clock   (i_joy_clock[1]),
    .o_pad_buttons (),
    .o_serial_bit  (o_joy_data[1])
  );

  mem_slot_scheduler u_sched (
    .clk              (clk),
    .sys_resetn       (sys_resetn),
    .i_loader_done    (i_loader_done),
    .i_cpu_read       (i_cpu_read),
    .i_ppu_read       (i_ppu_read),
    .i_nes_write      (i_nes_write),
    .i_nes_addr       (i_nes_addr),
    .i_nes_data       (i_nes_data),
    .i_loader_write   (i_loader_write),
    .i_loader_refresh (i_loader_refresh),
    .i_loader_addr    (i_loader_addr),
    .i_loader_data    (i_loader_data),
    .o_run_nes        (o_run_nes),
    .o_mem_read_cpu   (o_mem_read_cpu),
    .o_mem_read_ppu   (o_mem_read_ppu),
    .o_mem_write      (o_mem_write),
    .o_mem_refresh    (o_mem_refresh),
    .o_mem_addr       (o_mem_addr),
    .o_mem_data       (o_mem_data)
  );

endmodule

`default_nettype wire

//--- tb_nes_glue.sv
// self-checking testbench for the console glue top level
// stimulus from a 16-bit Galois LFSR seeded with 27, checked every cycle against a model
// inputs change on the rising edge, outputs are compared on the falling edge
`timescale 1ns/1ps
`default_nettype none

`include "nes_glue_params.svh"

module tb_nes_glue;

  localparam int N_RAND      = 300;                // cycles per random test
  localparam int TEST_CYCLES = 3 * N_RAND + 120;   // random tests plus directed parts and resets
  localparam int TIMEOUT_NS  = TEST_CYCLES * 8 + 400;

  logic                     clk;
  logic                     sys_resetn;
  nes_glue_pkg::host_addr_t i_host_addr;
  nes_glue_pkg::mem_data_t  i_host_data;
  logic                     i_host_write;
  nes_glue_pkg::ds_byte_t   i_ds_byte0_p1;
  nes_glue_pkg::ds_byte_t   i_ds_byte1_p1;
  nes_glue_pkg::nes_btn_t   i_usb_btn_p1;
  nes_glue_pkg::ds_byte_t   i_ds_byte0_p2;
  nes_glue_pkg::ds_byte_t   i_ds_byte1_p2;
  nes_glue_pkg::nes_btn_t   i_usb_btn_p2;
  logic                     i_joy_strobe;
  logic [1:0]               i_joy_clock;
  logic                     i_loader_done;
  logic                     i_cpu_read;
  logic                     i_ppu_read;
  logic                     i_nes_write;
  nes_glue_pkg::mem_addr_t  i_nes_addr;
  nes_glue_pkg::mem_data_t  i_nes_data;
  logic                     i_loader_write;
  logic                     i_loader_refresh;
  nes_glue_pkg::mem_addr_t  i_loader_addr;
  nes_glue_pkg::mem_data_t  i_loader_data;
  wire [1:0]                o_joy_data;
  wire nes_glue_pkg::mem_data_t o_loader_byte;
  wire                      o_loader_byte_valid;
  wire                      o_loader_reset;
  wire                      o_run_nes;
  wire                      o_mem_read_cpu;
  wire                      o_mem_read_ppu;
  wire                      o_mem_write;
  wire                      o_mem_refresh;
  wire nes_glue_pkg::mem_addr_t o_mem_addr;
  wire nes_glue_pkg::mem_data_t o_mem_data;

  // cycle model state
  nes_glue_pkg::mem_data_t m_conf;
  nes_glue_pkg::mem_data_t m_byte;
  nes_glue_pkg::nes_btn_t  m_ovr1;
  nes_glue_pkg::nes_btn_t  m_ovr2;
  nes_glue_pkg::nes_btn_t  m_sh1;
  nes_glue_pkg::nes_btn_t  m_sh2;
  logic                    m_valid;
  logic [1:0]              m_pclk;     // joypad clocks seen last cycle
  int                      m_phase;
  logic [15:0]             lfsr = 16'd27;

  nes_glue_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // galois step, taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);
    return b;
  endfunction

  function automatic logic [21:0] rand_bits(input int n);
    logic [21:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[20:0], lfsr_bit()};
    end
    return r;
  endfunction

  // raw bytes are active low, result in R L D U start select B A order
  function automatic nes_glue_pkg::nes_btn_t map_buttons(input nes_glue_pkg::ds_byte_t b0,
      input nes_glue_pkg::ds_byte_t b1, input nes_glue_pkg::nes_btn_t usb);
    nes_glue_pkg::nes_btn_t m;
    m[7] = ~b0[5];
    m[6] = ~b0[7];
    m[5] = ~b0[6];
    m[4] = ~b0[4];
    m[3] = ~b0[3];
    m[2] = ~b0[0];
    m[1] = ~b1[6];
    m[0] = ~b1[5];
    return m | usb;
  endfunction

  // half of the writes hit a mapped register
  function automatic nes_glue_pkg::host_addr_t pick_addr();
    logic [21:0] sel;
    sel = rand_bits(3);
    case (sel)
      22'd0:   return `HOST_REG_CONF;
      22'd1:   return `HOST_REG_DATA;
      22'd2:   return `HOST_REG_BTN1;
      22'd3:   return `HOST_REG_BTN2;
      default: return nes_glue_pkg::host_addr_t'(rand_bits(8));
    endcase
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_joy(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input nes_glue_pkg::mem_addr_t exp,
      input nes_glue_pkg::mem_addr_t act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input nes_glue_pkg::mem_data_t exp,
      input nes_glue_pkg::mem_data_t act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_outputs();
    nes_glue_pkg::nes_btn_t p1;
    logic                   run_mem;
    logic                   req;
    p1      = map_buttons(i_ds_byte0_p1, i_ds_byte1_p1, i_usb_btn_p1);
    run_mem = (m_phase == `MEM_PHASE) && i_loader_done;
    req     = i_cpu_read || i_ppu_read || i_nes_write;
    check_bit("o_loader_reset",
              !sys_resetn || m_conf[0] || (p1[`BTN_SELECT] && p1[`BTN_DOWN]), o_loader_reset);
    check_bit("o_loader_byte_valid", m_valid, o_loader_byte_valid);
    if (m_valid) begin
      check_data("o_loader_byte", m_byte, o_loader_byte);
    end
    check_joy("o_joy_data", {m_sh2[0], m_sh1[0]}, o_joy_data);
    check_bit("o_run_nes", (m_phase == `NES_PHASE) && i_loader_done, o_run_nes);
    check_bit("o_mem_read_cpu", i_cpu_read && run_mem, o_mem_read_cpu);
    check_bit("o_mem_read_ppu", i_ppu_read && run_mem, o_mem_read_ppu);
    check_bit("o_mem_write", (i_nes_write && run_mem) || i_loader_write, o_mem_write);
    check_bit("o_mem_refresh", (run_mem && !req && !i_loader_write)
              || (i_loader_refresh && !i_loader_write), o_mem_refresh);
    check_addr("o_mem_addr", i_loader_write ? i_loader_addr : i_nes_addr, o_mem_addr);
    check_data("o_mem_data", i_loader_write ? i_loader_data : i_nes_data, o_mem_data);
  endtask

  task automatic update_model();
    nes_glue_pkg::nes_btn_t p1;
    nes_glue_pkg::nes_btn_t p2;
    p1 = map_buttons(i_ds_byte0_p1, i_ds_byte1_p1, i_usb_btn_p1);
    p2 = map_buttons(i_ds_byte0_p2, i_ds_byte1_p2, i_usb_btn_p2);
    if (!sys_resetn) begin
      m_conf  = '0;
      m_ovr1  = '0;
      m_ovr2  = '0;
      m_sh1   = '0;
      m_sh2   = '0;
      m_valid = 1'b0;
      m_pclk  = '0;
      m_phase = `MEM_PHASE;
    end else begin
      if (i_joy_strobe) begin  // latch uses overrides from before this edge
        m_sh1 = m_ovr1 | p1;
        m_sh2 = m_ovr2 | p2;
      end else begin
        if (m_pclk[0] && !i_joy_clock[0]) begin
          m_sh1 = m_sh1 >> 1;
        end
        if (m_pclk[1] && !i_joy_clock[1]) begin
          m_sh2 = m_sh2 >> 1;
        end
      end
      m_pclk  = i_joy_clock;
      m_valid = i_host_write && (i_host_addr == `HOST_REG_DATA);
      if (i_host_write) begin
        case (i_host_addr)
          `HOST_REG_CONF: m_conf = i_host_data;
          `HOST_REG_DATA: m_byte = i_host_data;
          `HOST_REG_BTN1: m_ovr1 = i_host_data;
          `HOST_REG_BTN2: m_ovr2 = i_host_data;
          default: ;
        endcase
      end
      m_phase = (m_phase + 1) % `NES_PHASES;
    end
  endtask

  task automatic tick();
    @(negedge clk);
    check_outputs();
    @(posedge clk);
    update_model();
  endtask

  task automatic release_pads();
    i_ds_byte0_p1 <= 8'hFF;
    i_ds_byte1_p1 <= 8'hFF;
    i_ds_byte0_p2 <= 8'hFF;
    i_ds_byte1_p2 <= 8'hFF;
    i_usb_btn_p1  <= '0;
    i_usb_btn_p2  <= '0;
  endtask

  task automatic rand_pads();
    i_ds_byte0_p1 <= nes_glue_pkg::ds_byte_t'(rand_bits(8));
    i_ds_byte1_p1 <= nes_glue_pkg::ds_byte_t'(rand_bits(8));
    i_ds_byte0_p2 <= nes_glue_pkg::ds_byte_t'(rand_bits(8));
    i_ds_byte1_p2 <= nes_glue_pkg::ds_byte_t'(rand_bits(8));
    i_usb_btn_p1  <= nes_glue_pkg::nes_btn_t'(rand_bits(8) & rand_bits(8));  // sparse
    i_usb_btn_p2  <= nes_glue_pkg::nes_btn_t'(rand_bits(8) & rand_bits(8));
    i_joy_strobe  <= (rand_bits(3) == 22'd0);
    i_joy_clock   <= 2'(rand_bits(2));
  endtask

  task automatic rand_mem();
    i_cpu_read       <= lfsr_bit();
    i_ppu_read       <= lfsr_bit();
    i_nes_write      <= lfsr_bit();
    i_nes_addr       <= rand_bits(22);
    i_nes_data       <= nes_glue_pkg::mem_data_t'(rand_bits(8));
    i_loader_write   <= (rand_bits(2) == 22'd0);
    i_loader_refresh <= lfsr_bit();
    i_loader_addr    <= rand_bits(22);
    i_loader_data    <= nes_glue_pkg::mem_data_t'(rand_bits(8));
  endtask

  task automatic host_write(input nes_glue_pkg::host_addr_t addr,
      input nes_glue_pkg::mem_data_t data);
    i_host_addr  <= addr;
    i_host_data  <= data;
    i_host_write <= 1'b1;
    tick();
    i_host_write <= 1'b0;
    tick();
  endtask

  // strobe then nine clock pulses, the last bit after the byte is 0
  task automatic read_pads();
    i_joy_strobe <= 1'b1;
    tick();
    i_joy_strobe <= 1'b0;
    repeat (9) begin
      i_joy_clock <= 2'b11;
      tick();
      i_joy_clock <= 2'b00;
      tick();
    end
  endtask

  task automatic apply_reset();
    sys_resetn <= 1'b0;
    repeat (3) tick();
    sys_resetn <= 1'b1;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout, test sequence did not finish within %0d ns", TIMEOUT_NS);
    abort_run();
  end

  initial begin
    sys_resetn    <= 1'b0;
    i_host_addr   <= '0;
    i_host_data   <= '0;
    i_host_write  <= 1'b0;
    i_joy_strobe  <= 1'b0;
    i_joy_clock   <= 2'b00;
    i_loader_done <= 1'b0;
    release_pads();
    rand_mem();
    @(posedge clk);
    update_model();
    repeat (2) tick();
    sys_resetn <= 1'b1;

    // override bytes come out LSB first with the pads released
    host_write(`HOST_REG_BTN1, nes_glue_pkg::mem_data_t'(rand_bits(8)));
    host_write(`HOST_REG_BTN2, nes_glue_pkg::mem_data_t'(rand_bits(8)));
    read_pads();

    // random host traffic, ROM bytes and loader config
    repeat (N_RAND) begin
      i_host_addr  <= pick_addr();
      i_host_data  <= nes_glue_pkg::mem_data_t'(rand_bits(8));
      i_host_write <= lfsr_bit();
      tick();
    end
    host_write(`HOST_REG_CONF, 8'h00);  // release loader so the hotkey shows

    repeat (N_RAND) begin
      rand_pads();
      tick();
    end

    // core held off while the loader is busy
    i_loader_done <= 1'b0;
    repeat (30) begin
      rand_mem();
      tick();
    end
    i_loader_done <= 1'b1;
    apply_reset();
    repeat (50) begin
      rand_mem();
      tick();
    end

    repeat (N_RAND) begin
      rand_mem();
      i_loader_done <= (rand_bits(3) != 22'd0);
      tick();
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
nes_glue_pkg.sv
host_reg_bank.sv
joypad_port.sv
mem_slot_scheduler.sv
nes_glue_top.sv
tb_nes_glue.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_nes_glue -f sim.f -o tb_nes_glue \
  && ./obj_dir/tb_nes_glue 2>&1 | tee sim.log
grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
